/* verilog/prefix_pkg.sv */
/*
  shared widths and vector types for the 64-bit Han-Carlson add/subtract unit.
  the prefix tree is built for exactly 64 bits, so changing data_width alone
  does not produce a working adder of another width.
*/
`default_nettype none

package prefix_pkg;

   // operand width fixed by the tree shape
   localparam int data_width = 64;

   // bit pairs combined by the tree
   localparam int pair_count = data_width / 2;

   // pair merge plus five span-doubling levels
   localparam int tree_levels = 6;

   // operands and sums
   typedef logic [data_width-1:0] word_t;

   // index 0 is the carry-in slot and 1..64 are bit positions
   typedef logic [data_width:0] pg_vec_t;

   // one entry per bit pair
   typedef logic [pair_count-1:0] group_vec_t;

endpackage

`default_nettype wire

/* verilog/pg_generate.sv */
/*
  bitwise propagate and generate for the prefix adder.
  position 0 carries the carry-in as a generate with zero propagate,
  so the tree needs no separate carry-in path.
*/
`timescale 1ns/1ps
`default_nettype none

module pg_generate
   import prefix_pkg::*;
(
   input  word_t   a,
   input  word_t   b,
   input  logic    cin,
   output pg_vec_t p,
   output pg_vec_t g
);

   // carry-in slot
   assign g[0] = cin;
   assign p[0] = 1'b0;

   // operand bit i lands on position i+1
   assign p[data_width:1] = a ^ b;
   assign g[data_width:1] = a & b;

endmodule

`default_nettype wire

/* verilog/han_carlson_tree.sv */
/*
  Han-Carlson prefix tree over the odd/even bit pairs.
  output entry k is the carry into position 2k+2 (pg_vec_t numbering).
  odd carries are not produced here; sum_resolve adds the last level.
  purely combinational, six logic levels deep.
*/
`timescale 1ns/1ps
`default_nettype none

module han_carlson_tree
   import prefix_pkg::*;
(
   input  pg_vec_t    p,
   input  pg_vec_t    g,
   output group_vec_t group_g
);

   // level index 0 is the pair merge, 1..5 the span-doubling levels
   group_vec_t gg_lvl [tree_levels];

   // last level needs no group propagate
   group_vec_t pp_lvl [tree_levels-1];

   genvar lvl;
   genvar k;

   // level 1 merges odd position 2k+1 with even position 2k below it
   generate
      for (k = 0; k < pair_count; k++) begin : g_pair
         assign gg_lvl[0][k] = g[2*k+1] | (p[2*k+1] & g[2*k]);
         assign pp_lvl[0][k] = p[2*k+1] & p[2*k];
      end
   endgenerate

   // levels 2..6 with spans 1, 2, 4, 8, 16 over the pair signals
   generate
      for (lvl = 1; lvl < tree_levels; lvl++) begin : g_level
         localparam int span = 1 << (lvl - 1);

         for (k = 0; k < pair_count; k++) begin : g_entry
            if (k >= span) begin : g_combine
               assign gg_lvl[lvl][k] = gg_lvl[lvl-1][k] |
                                       (pp_lvl[lvl-1][k] & gg_lvl[lvl-1][k-span]);
            end else begin : g_pass
               // already complete with nothing left below
               assign gg_lvl[lvl][k] = gg_lvl[lvl-1][k];
            end

            if (lvl < tree_levels - 1) begin : g_prop
               if (k >= span) begin : g_pcombine
                  assign pp_lvl[lvl][k] = pp_lvl[lvl-1][k] & pp_lvl[lvl-1][k-span];
               end else begin : g_ppass
                  assign pp_lvl[lvl][k] = pp_lvl[lvl-1][k];
               end
            end
         end
      end
   endgenerate

   assign group_g = gg_lvl[tree_levels-1];

endmodule

`default_nettype wire

/* verilog/sum_resolve.sv */
/*
  final Han-Carlson level and sum formation.
  even positions take their carry straight from the tree; odd positions
  need one more combine with the even position just below.
  position numbering follows pg_vec_t, so sum bit j is position j+1.
*/
`timescale 1ns/1ps
`default_nettype none

module sum_resolve
   import prefix_pkg::*;
(
   input  pg_vec_t    p,
   input  pg_vec_t    g,
   input  group_vec_t group_g,
   input  logic       cin,
   output word_t      sum,
   output logic       cout
);

   // rebuilt carries into odd positions 3, 5, .. 63
   logic [pair_count-1:1] odd_carry;

   genvar i;

   // position 1 sees the carry-in directly
   assign sum[0] = cin ^ p[1];

   // even positions 2i
   generate
      for (i = 1; i <= pair_count; i++) begin : g_even
         assign sum[2*i-1] = p[2*i] ^ group_g[i-1];
      end
   endgenerate

   // odd positions 2i+1 need one extra combine each
   generate
      for (i = 1; i < pair_count; i++) begin : g_odd
         assign odd_carry[i] = g[2*i] | (p[2*i] & group_g[i-1]);
         assign sum[2*i]     = p[2*i+1] ^ odd_carry[i];
      end
   endgenerate

   assign cout = g[data_width] | (p[data_width] & group_g[pair_count-1]);

endmodule

`default_nettype wire

/* verilog/hc_adder_64.sv */
/*
  combinational 64-bit Han-Carlson adder, 65-bit result as sum plus cout.
  no registers inside; the surrounding pipeline sets the timing.
*/
`timescale 1ns/1ps
`default_nettype none

module hc_adder_64
   import prefix_pkg::*;
(
   input  word_t a,
   input  word_t b,
   input  logic  cin,
   output word_t sum,
   output logic  cout
);

   pg_vec_t    p;
   pg_vec_t    g;
   group_vec_t group_g;

   pg_generate pg_generate_inst (
      .a   (a),
      .b   (b),
      .cin (cin),
      .p   (p),
      .g   (g)
   );

   han_carlson_tree han_carlson_tree_inst (
      .p       (p),
      .g       (g),
      .group_g (group_g)
   );

   sum_resolve sum_resolve_inst (
      .p       (p),
      .g       (g),
      .group_g (group_g),
      .cin     (cin),
      .sum     (sum),
      .cout    (cout)
   );

endmodule

`default_nettype wire

/* verilog/operand_stage.sv */
/*
  first pipeline register. subtraction becomes a + ~b + 1, so the adder
  only ever adds; carry_in is ignored when sub is set.
  operands load only on in_valid, there is no stall.
*/
`timescale 1ns/1ps
`default_nettype none

module operand_stage
   import prefix_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  logic  in_valid,
   input  word_t a,
   input  word_t b,
   input  logic  carry_in,
   input  logic  sub,
   output logic  op_valid,
   output word_t op_a,
   output word_t op_b,
   output logic  op_cin
);

   always_ff @(posedge clk) begin
      if (reset) begin
         op_valid <= 1'b0;
      end else begin
         op_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid) begin
         op_a <= a;
         // two's complement negate with the +1 as carry-in
         op_b   <= sub ? ~b : b;
         op_cin <= sub ? 1'b1 : carry_in;
      end
   end

endmodule

`default_nettype wire

/* verilog/result_stage.sv */
/*
  second pipeline register with the status flags.
  overflow uses the adder's own operands, so for a subtraction it sees ~b.
  carry_out after a subtraction reads as "no borrow".
  out_valid is a one-cycle strobe; the consumer cannot stall it.
*/
`timescale 1ns/1ps
`default_nettype none

module result_stage
   import prefix_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  logic  op_valid,
   input  word_t op_a,
   input  word_t op_b,
   input  word_t sum,
   input  logic  cout,
   output logic  out_valid,
   output word_t result,
   output logic  carry_out,
   output logic  overflow,
   output logic  zero
);

   logic sign_a;
   logic sign_b;
   logic sign_s;
   logic ovf_next;

   assign sign_a = op_a[data_width-1];
   assign sign_b = op_b[data_width-1];
   assign sign_s = sum[data_width-1];

   // like-signed operands giving an unlike-signed sum
   assign ovf_next = (sign_a == sign_b) && (sign_s != sign_a);

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= op_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (op_valid) begin
         result    <= sum;
         carry_out <= cout;
         overflow  <= ovf_next;
         zero      <= (sum == '0);
      end
   end

endmodule

`default_nettype wire

/* verilog/hc_addsub_top.sv */
/*
  registered 64-bit add/subtract unit around the Han-Carlson adder.
  one operation per cycle on in_valid, result 2 cycles later on out_valid.
  no back-pressure: every out_valid strobe must be taken when it appears.
  sub set means a - b and carry_in is then ignored.
*/
`timescale 1ns/1ps
`default_nettype none

module hc_addsub_top
   import prefix_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  logic  in_valid,
   input  word_t a,
   input  word_t b,
   input  logic  carry_in,
   input  logic  sub,
   output logic  out_valid,
   output word_t result,
   output logic  carry_out,
   output logic  overflow,
   output logic  zero
);

   logic  op_valid;
   word_t op_a;
   word_t op_b;
   logic  op_cin;
   word_t sum;
   logic  cout;

   operand_stage operand_stage_inst (
      .clk      (clk),
      .reset    (reset),
      .in_valid (in_valid),
      .a        (a),
      .b        (b),
      .carry_in (carry_in),
      .sub      (sub),
      .op_valid (op_valid),
      .op_a     (op_a),
      .op_b     (op_b),
      .op_cin   (op_cin)
   );

   // combinational between the two registers
   hc_adder_64 hc_adder_64_inst (
      .a    (op_a),
      .b    (op_b),
      .cin  (op_cin),
      .sum  (sum),
      .cout (cout)
   );

   result_stage result_stage_inst (
      .clk       (clk),
      .reset     (reset),
      .op_valid  (op_valid),
      .op_a      (op_a),
      .op_b      (op_b),
      .sum       (sum),
      .cout      (cout),
      .out_valid (out_valid),
      .result    (result),
      .carry_out (carry_out),
      .overflow  (overflow),
      .zero      (zero)
   );

endmodule

`default_nettype wire

/* tests/hc_addsub_tb.sv */
/*
  self-checking testbench for hc_addsub_top.
  expected values come from 65-bit arithmetic on the add/subtract rules.
  stops at the first mismatch; the random part is seeded, so every run repeats.
*/
`timescale 1ns/1ps
`default_nettype none

module hc_addsub_tb
   import prefix_pkg::*;
();

   localparam int random_ops   = 200;
   localparam int wait_limit   = 20;
   localparam int reset_cycles = 4;

   // stimulus, expected response and the cycle it was issued in
   typedef struct packed {
      word_t       a;
      word_t       b;
      logic        cin;
      logic        sub;
      word_t       result;
      logic        carry;
      logic        ovf;
      logic        zero;
      logic [31:0] issued_at;
   } row_t;

   logic  clk;
   logic  reset;
   logic  in_valid;
   word_t a;
   word_t b;
   logic  carry_in;
   logic  sub;
   logic  out_valid;
   word_t result;
   logic  carry_out;
   logic  overflow;
   logic  zero;

   logic [31:0] cycle_count = '0;
   row_t        table_q [$];
   row_t        pending_q [$];

   hc_addsub_top hc_addsub_top_inst (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .a         (a),
      .b         (b),
      .carry_in  (carry_in),
      .sub       (sub),
      .out_valid (out_valid),
      .result    (result),
      .carry_out (carry_out),
      .overflow  (overflow),
      .zero      (zero)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // rising edges seen so far for the latency check
   always @(posedge clk) begin
      cycle_count <= cycle_count + 32'd1;
   end

   task automatic fail_and_stop(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1, "testbench stopped");
   endtask

   task automatic check_word(input string name, input word_t got, input word_t expected);
      if (got !== expected) begin
         fail_and_stop($sformatf("** Error: %s is %h, expected %h", name, got, expected));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic expected);
      if (got !== expected) begin
         fail_and_stop($sformatf("** Error: %s is %h, expected %h", name, got, expected));
      end
   endtask

   // reference model in plain 65-bit arithmetic
   function automatic row_t make_row(input word_t op_a, input word_t op_b,
                                     input logic cin, input logic sub_op);
      row_t        r;
      logic [64:0] full;
      logic [64:0] sfull;
      r        = '0;
      r.a      = op_a;
      r.b      = op_b;
      r.cin    = cin;
      r.sub    = sub_op;
      if (sub_op) begin
         full     = {1'b0, op_a} - {1'b0, op_b};
         sfull    = {op_a[63], op_a} - {op_b[63], op_b};
         r.result = full[63:0];
         // no borrow
         r.carry  = (op_a >= op_b);
      end else begin
         full     = {1'b0, op_a} + {1'b0, op_b} + 65'(cin);
         sfull    = {op_a[63], op_a} + {op_b[63], op_b} + 65'(cin);
         r.result = full[63:0];
         r.carry  = full[64];
      end
      // signed result does not fit in 64 bits
      r.ovf  = (sfull[64] != sfull[63]);
      r.zero = (r.result == '0);
      return r;
   endfunction

   task automatic build_table();
      int    k;
      word_t bit_lo;
      word_t bit_hi;
      table_q.push_back(make_row(64'h0, 64'h0, 1'b0, 1'b0));
      table_q.push_back(make_row(64'h0, 64'h0, 1'b1, 1'b0));
      // carries at every pair boundary in even and odd positions
      for (k = 0; k < pair_count; k++) begin
         bit_lo = 64'd1 << (2 * k);
         bit_hi = 64'd1 << (2 * k + 1);
         table_q.push_back(make_row(bit_lo, bit_lo, 1'b0, 1'b0));
         table_q.push_back(make_row(bit_hi, bit_hi, 1'b0, 1'b0));
         table_q.push_back(make_row(bit_hi | bit_lo, bit_lo, 1'b0, 1'b0));
      end
      // full ripple through the tree
      table_q.push_back(make_row(64'hffff_ffff_ffff_ffff, 64'h1, 1'b0, 1'b0));
      table_q.push_back(make_row(64'hffff_ffff_ffff_ffff, 64'h0, 1'b1, 1'b0));
      table_q.push_back(make_row(64'haaaa_aaaa_aaaa_aaaa, 64'h5555_5555_5555_5555, 1'b1, 1'b0));
      table_q.push_back(make_row(64'h5555_5555_5555_5555, 64'h5555_5555_5555_5555, 1'b1, 1'b0));
      table_q.push_back(make_row(64'haaaa_aaaa_aaaa_aaaa, 64'haaaa_aaaa_aaaa_aaaa, 1'b1, 1'b0));
      // signed overflow corners
      table_q.push_back(make_row(64'h7fff_ffff_ffff_ffff, 64'h1, 1'b0, 1'b0));
      table_q.push_back(make_row(64'h8000_0000_0000_0000, 64'h1, 1'b0, 1'b1));
      table_q.push_back(make_row(64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 1'b0, 1'b0));
      table_q.push_back(make_row(64'h0, 64'h8000_0000_0000_0000, 1'b0, 1'b1));
      // subtraction, borrow and zero
      table_q.push_back(make_row(64'h1234_5678_9abc_def0, 64'h1234_5678_9abc_def0, 1'b0, 1'b1));
      table_q.push_back(make_row(64'h5, 64'h7, 1'b0, 1'b1));
      table_q.push_back(make_row(64'h0, 64'h0, 1'b0, 1'b1));
      table_q.push_back(make_row(64'ha, 64'h3, 1'b1, 1'b1));
      table_q.push_back(make_row(64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff, 1'b0, 1'b1));
      table_q.push_back(make_row(64'h0, 64'h1, 1'b0, 1'b1));
   endtask

   // one strobe on the next falling edge; in_valid stays high for back-to-back use
   task automatic issue_op(input row_t r);
      row_t entry;
      @(negedge clk);
      entry           = r;
      entry.issued_at = cycle_count;
      in_valid        = 1'b1;
      a               = r.a;
      b               = r.b;
      carry_in        = r.cin;
      sub             = r.sub;
      pending_q.push_back(entry);
   endtask

   task automatic drive_all();
      int          idx;
      int          n;
      logic [31:0] coin;
      word_t       ra;
      word_t       rb;
      for (idx = 0; idx < table_q.size(); idx++) begin
         issue_op(table_q[idx]);
      end
      // one idle cycle before the random part
      @(negedge clk);
      in_valid = 1'b0;
      for (n = 0; n < random_ops; n++) begin
         ra   = {$urandom, $urandom};
         rb   = {$urandom, $urandom};
         coin = $urandom;
         // some equal operands to hit zero
         if (coin[4:2] == 3'd0) begin
            rb = ra;
         end
         issue_op(make_row(ra, rb, coin[0], coin[1]));
      end
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   task automatic wait_out_valid();
      int waited;
      waited = 0;
      @(negedge clk);
      while (out_valid !== 1'b1) begin
         if (waited >= wait_limit) begin
            fail_and_stop("timeout: out_valid did not rise within 20 cycles");
         end else begin
            waited++;
            @(negedge clk);
         end
      end
   endtask

   task automatic collect_all(input int total);
      int   n;
      row_t exp_row;
      for (n = 0; n < total; n++) begin
         wait_out_valid();
         if (pending_q.size() == 0) begin
            fail_and_stop("out_valid rose with no operation in flight");
         end else begin
            exp_row = pending_q.pop_front();
            if (cycle_count != exp_row.issued_at + 32'd2) begin
               fail_and_stop($sformatf("result %0d came out at cycle %0d, issued at cycle %0d",
                                       n, cycle_count, exp_row.issued_at));
            end
            check_word("result", result, exp_row.result);
            check_flag("carry_out", carry_out, exp_row.carry);
            check_flag("overflow", overflow, exp_row.ovf);
            check_flag("zero", zero, exp_row.zero);
         end
      end
   endtask

   initial begin
      int total;
      int n;
      reset    = 1'b1;
      in_valid = 1'b0;
      a        = '0;
      b        = '0;
      carry_in = 1'b0;
      sub      = 1'b0;
      void'($urandom(69));
      build_table();
      total = table_q.size() + random_ops;

      for (n = 0; n < reset_cycles; n++) begin
         @(negedge clk);
         check_flag("out_valid", out_valid, 1'b0);
      end
      reset = 1'b0;

      fork
         drive_all();
         collect_all(total);
      join

      // no stray strobes after the last result
      for (n = 0; n < 4; n++) begin
         @(negedge clk);
         check_flag("out_valid", out_valid, 1'b0);
      end

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
verilog/prefix_pkg.sv
verilog/pg_generate.sv
verilog/han_carlson_tree.sv
verilog/sum_resolve.sv
verilog/hc_adder_64.sv
verilog/operand_stage.sv
verilog/result_stage.sv
verilog/hc_addsub_top.sv
tests/hc_addsub_tb.sv

/* Makefile */
# Verilator simulation of the Han-Carlson add/subtract unit

TOP = hc_addsub_tb

.PHONY: sim clean

sim:
	verilator --binary -f files.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
